// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module tb_debug_monitor -Mdir obj_dir
	out=$$(./obj_dir/Vtb_debug_monitor); echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// File: files.f
+incdir+hw
hw/gnn_pkg.sv
hw/dbg_pkg.sv
hw/activity_tracker.sv
hw/sample_capture.sv
hw/debug_readout.sv
hw/debug_monitor_top.sv
verification/debug_monitor_assertions.sv
verification/tb_debug_monitor.sv

// File: hw/activity_tracker.sv
`timescale 1ns/10ps

`include "gnn_defines.svh"

module activity_tracker
  import gnn_pkg::*;
  import dbg_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  stage_strobes_t stage_i,
  input  feat_wr_t       feat_wr_i,
  input  logic           clear_i,
  output dbg_status_u    status_o,
  output sm_count_t      sm_count_o,
  output dbg_word_t      feat_count_o
);

  dbg_status_u status_q;
  sm_count_t   sm_count_q;
  dbg_word_t   feat_count_q;
  logic        feat_ovf;

  // writes past the end of the feature buffer.
  assign feat_ovf = feat_wr_i.ena && (feat_wr_i.addr >= `FEAT_OVF_ADDR);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_q.raw <= '0;
    end else if (clear_i) begin
      status_q.raw <= '0;                                  // clear beats a same-cycle event.
    end else begin
      status_q.fields.rsvd  <= '0;
      status_q.fields.stage <= status_q.fields.stage | stage_i;
      if (feat_wr_i.ena) begin
        status_q.fields.feat_ena_seen <= 1'b1;
      end
      if (feat_ovf) begin
        status_q.fields.feat_ovf_seen <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_count_q <= '0;
    end else if (clear_i) begin
      sm_count_q <= '0;
    end else if (stage_i.sm_vld) begin
      sm_count_q <= sm_count_q + sm_count_t'(1);          // wraps.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_count_q <= '0;
    end else if (clear_i) begin
      feat_count_q <= '0;
    end else if (feat_wr_i.ena) begin
      feat_count_q <= feat_count_q + dbg_word_t'(1);
    end
  end

  assign status_o     = status_q;
  assign sm_count_o   = sm_count_q;
  assign feat_count_o = feat_count_q;

endmodule

// File: hw/dbg_pkg.sv
`include "gnn_defines.svh"

package dbg_pkg;

  import gnn_pkg::*;

  typedef logic [31:0] dbg_word_t;
  typedef logic [`SM_CNT_W-1:0] sm_count_t;

  typedef struct packed {
    logic [21:0]    rsvd;          // always zero.
    logic           feat_ovf_seen;
    logic           feat_ena_seen;
    stage_strobes_t stage;         // sticky stage flags.
  } dbg_status_fields_t;

  // same 32 bits, seen as flags or as the bus word.
  typedef union packed {
    dbg_word_t          raw;
    dbg_status_fields_t fields;
  } dbg_status_u;

  typedef enum logic [`DBG_ADDR_W-1:0] {
    REG_SIGNATURE = 3'd0,
    REG_CONFIG    = 3'd1,
    REG_STATUS    = 3'd2,
    REG_SM_CNT_LO = 3'd3,
    REG_SM_CNT_HI = 3'd4,
    REG_CAP_A     = 3'd5,
    REG_CAP_B     = 3'd6,
    REG_FEAT_CNT  = 3'd7
  } dbg_reg_e;

  typedef struct packed {
    logic     strobe;
    dbg_reg_e addr;
  } dbg_rd_req_t;

  typedef struct packed {
    dbg_status_u status;
    sm_count_t   sm_count;
    dbg_word_t   feat_count;
    sppe_lane_t  cap_a;
    sppe_lane_t  cap_b;
  } dbg_records_t;

endpackage

// File: hw/debug_monitor_top.sv
`timescale 1ns/10ps

module debug_monitor_top
  import gnn_pkg::*;
  import dbg_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  stage_strobes_t stage_i,
  input  feat_wr_t       feat_wr_i,
  input  sppe_bus_t      sppe_i,
  input  wh_addr_t       wh_addr_i,
  input  logic           clear_i,
  input  dbg_rd_req_t    rd_req_i,
  output dbg_word_t      rd_data_o,
  output logic           rd_vld_o
);

  dbg_status_u  status;
  sm_count_t    sm_count;
  dbg_word_t    feat_count;
  sppe_lane_t   cap_a;
  sppe_lane_t   cap_b;
  dbg_records_t records;

  activity_tracker u_activity_tracker (
    .clk          (clk),
    .rst_n        (rst_n),
    .stage_i      (stage_i),
    .feat_wr_i    (feat_wr_i),
    .clear_i      (clear_i),
    .status_o     (status),
    .sm_count_o   (sm_count),
    .feat_count_o (feat_count)
  );

  sample_capture u_sample_capture (
    .clk        (clk),
    .rst_n      (rst_n),
    .sppe_i     (sppe_i),
    .wh_addr_i  (wh_addr_i),
    .spmm_rdy_i (stage_i.spmm_rdy),   // capture gate.
    .clear_i    (clear_i),
    .cap_a_o    (cap_a),
    .cap_b_o    (cap_b)
  );

  // the full register bank as seen by the host.
  assign records.status     = status;
  assign records.sm_count   = sm_count;
  assign records.feat_count = feat_count;
  assign records.cap_a      = cap_a;
  assign records.cap_b      = cap_b;

  debug_readout u_debug_readout (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_req_i  (rd_req_i),
    .records_i (records),
    .rd_data_o (rd_data_o),
    .rd_vld_o  (rd_vld_o)
  );

endmodule

// File: hw/debug_readout.sv
`timescale 1ns/10ps

`include "gnn_defines.svh"

module debug_readout
  import dbg_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  dbg_rd_req_t  rd_req_i,
  input  dbg_records_t records_i,
  output dbg_word_t    rd_data_o,
  output logic         rd_vld_o
);

  dbg_word_t rd_word;
  dbg_word_t rd_data_q;
  logic      rd_vld_q;

  // register mux.
  always_comb begin
    case (rd_req_i.addr)
      REG_SIGNATURE: begin
        rd_word = `DBG_SIGNATURE;
      end
      REG_CONFIG: begin
        rd_word = `H_NUM_SPARSE_DATA;
      end
      REG_STATUS: begin
        rd_word = records_i.status.raw;
      end
      REG_SM_CNT_LO: begin
        rd_word = records_i.sm_count[31:0];
      end
      REG_SM_CNT_HI: begin
        rd_word = dbg_word_t'(records_i.sm_count[`SM_CNT_W-1:32]);   // upper 16 bits.
      end
      REG_CAP_A: begin
        rd_word = dbg_word_t'(records_i.cap_a);
      end
      REG_CAP_B: begin
        rd_word = dbg_word_t'(records_i.cap_b);
      end
      REG_FEAT_CNT: begin
        rd_word = records_i.feat_count;
      end
      default: begin
        rd_word = '0;
      end
    endcase
  end

  // data only moves on a request.
  always_ff @(posedge clk) begin
    if (rd_req_i.strobe) begin
      rd_data_q <= rd_word;
    end
  end

  // one response pulse per request.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= rd_req_i.strobe;
    end
  end

  assign rd_data_o = rd_data_q;
  assign rd_vld_o  = rd_vld_q;

endmodule

// File: hw/gnn_defines.svh
`ifndef GNN_DEFINES_SVH
`define GNN_DEFINES_SVH

// feature memory port.
`define FEAT_ADDR_W       16
`define FEAT_DATA_W       32
`define FEAT_OVF_ADDR     16'd43328

// sparse PE array and weight memory.
`define SPPE_LANES        16
`define SPPE_W            12
`define WH_ADDR_W         14

// capture points on the spmm lane.
`define CAPTURE_LANE      2
`define CAPTURE_ADDR_A    14'd10
`define CAPTURE_ADDR_B    14'd20

// debug register bank.
`define H_NUM_SPARSE_DATA 32'd12
`define DBG_SIGNATURE     32'd12062103
`define DBG_ADDR_W        3
`define SM_CNT_W          48

`endif

// File: hw/gnn_pkg.sv
`include "gnn_defines.svh"

package gnn_pkg;

  // valid/ready pairs of the four engines, spmm in the top bits.
  typedef struct packed {
    logic spmm_vld;
    logic spmm_rdy;
    logic dmvm_vld;
    logic dmvm_rdy;
    logic sm_vld;
    logic sm_rdy;
    logic aggr_vld;
    logic aggr_rdy;
  } stage_strobes_t;

  typedef logic [`FEAT_ADDR_W-1:0] feat_addr_t;
  typedef logic [`FEAT_DATA_W-1:0] feat_data_t;

  // feature memory write port A.
  typedef struct packed {
    logic       ena;
    feat_addr_t addr;
    feat_data_t data;
  } feat_wr_t;

  typedef logic [`SPPE_W-1:0] sppe_lane_t;

  // one word per sparse PE lane.
  typedef sppe_lane_t [`SPPE_LANES-1:0] sppe_bus_t;

  typedef logic [`WH_ADDR_W-1:0] wh_addr_t;

endpackage

// File: hw/sample_capture.sv
`timescale 1ns/10ps

`include "gnn_defines.svh"

module sample_capture
  import gnn_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  sppe_bus_t  sppe_i,
  input  wh_addr_t   wh_addr_i,
  input  logic       spmm_rdy_i,
  input  logic       clear_i,
  output sppe_lane_t cap_a_o,
  output sppe_lane_t cap_b_o
);

  sppe_lane_t lane;
  logic       hit_a;
  logic       hit_b;
  sppe_lane_t cap_a_q;
  sppe_lane_t cap_b_q;

  assign lane  = sppe_i[`CAPTURE_LANE];

  // sample only while spmm is ready.
  assign hit_a = spmm_rdy_i && (wh_addr_i == `CAPTURE_ADDR_A);
  assign hit_b = spmm_rdy_i && (wh_addr_i == `CAPTURE_ADDR_B);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_a_q <= '0;
    end else if (clear_i) begin
      cap_a_q <= '0;
    end else if (hit_a) begin
      cap_a_q <= lane;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_b_q <= '0;
    end else if (clear_i) begin
      cap_b_q <= '0;
    end else if (hit_b) begin
      cap_b_q <= lane;
    end
  end

  assign cap_a_o = cap_a_q;
  assign cap_b_o = cap_b_q;

endmodule

// File: verification/debug_monitor_assertions.sv
`timescale 1ns/10ps

module debug_monitor_assertions
  import dbg_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        clear_i,
  input dbg_rd_req_t rd_req_i,
  input logic        rd_vld_i,
  input sm_count_t   sm_count_i
);

  property p_vld_after_req;
    @(posedge clk) disable iff (!rst_n) rd_req_i.strobe |=> rd_vld_i;
  endproperty

  property p_vld_needs_req;
    @(posedge clk) disable iff (!rst_n) rd_vld_i |-> $past(rd_req_i.strobe);
  endproperty

  // only a clear may pull the count down.
  property p_sm_count_monotonic;
    @(posedge clk) disable iff (!rst_n) !$past(clear_i) |-> (sm_count_i >= $past(sm_count_i));
  endproperty

  a_vld_after_req: assert property (p_vld_after_req)
    else $error("read request not answered in the following cycle");

  a_vld_needs_req: assert property (p_vld_needs_req)
    else $error("read response without a request");

  a_sm_count_monotonic: assert property (p_sm_count_monotonic)
    else $error("softmax count went down without a clear");

endmodule

bind debug_monitor_top debug_monitor_assertions u_debug_monitor_assertions (
  .clk        (clk),
  .rst_n      (rst_n),
  .clear_i    (clear_i),
  .rd_req_i   (rd_req_i),
  .rd_vld_i   (rd_vld_o),
  .sm_count_i (sm_count)
);

// File: verification/debug_monitor_tests.txt
# E stage(hex: spmm v/r, dmvm v/r, sm v/r, aggr v/r) feat_ena feat_addr wh_addr lane2(hex)
# C stage(hex) | R reg expected(hex) | S ovf ena stage(hex) | T test name
R 0 00b80d97
R 1 0000000c
R 2 00000000
R 3 00000000
R 4 00000000
R 5 00000000
R 6 00000000
R 7 00000000
T reset_values
E 80 0 0 0 000
E 20 0 0 0 000
E 04 0 0 0 000
S 0 0 a4
E 40 0 0 0 000
E 10 0 0 0 000
E 08 0 0 0 000
E 02 0 0 0 000
E 01 0 0 0 000
S 0 0 ff
C 00
S 0 0 00
T stage_flags
E 08 0 0 0 000
E 08 0 0 0 000
E 08 0 0 0 000
R 3 00000003
R 4 00000000
C 08
R 3 00000000
T sm_count
E 40 0 0 10 abc
E 00 0 0 10 111
E 40 0 0 11 222
E 40 0 0 20 5a5
E 80 0 0 20 333
R 5 00000abc
R 6 000005a5
T captures
C 00
E 00 1 100 0 000
E 00 0 50000 0 000
E 00 1 43327 0 000
S 0 1 00
E 00 1 43328 0 000
S 1 1 00
R 7 00000003
T feature_writes

// File: verification/tb_debug_monitor.sv
`timescale 1ns/10ps

`include "gnn_defines.svh"

module tb_debug_monitor
  import gnn_pkg::*;
  import dbg_pkg::*;
();

  typedef struct packed {
    logic [7:0]     kind;
    stage_strobes_t stage;
    logic           feat_ena;
    feat_addr_t     feat_addr;
    wh_addr_t       wh_addr;
    dbg_reg_e       rd_addr;
    dbg_word_t      value;       // lane-2 sample or expected word.
  } test_rec_t;

  logic           clk;
  logic           rst_n;
  stage_strobes_t stage;
  feat_wr_t       feat_wr;
  sppe_bus_t      sppe;
  wh_addr_t       wh_addr;
  logic           clear;
  dbg_rd_req_t    rd_req;
  dbg_word_t      rd_data;
  logic           rd_vld;

  test_rec_t   recs[$];
  string       names[$];
  logic [31:0] rng_state = 32'd96853;
  bit          loaded = 1'b0;
  int          checks = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          test_checks = 0;
  int          test_errors = 0;

  debug_monitor_top u_debug_monitor_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .stage_i   (stage),
    .feat_wr_i (feat_wr),
    .sppe_i    (sppe),
    .wh_addr_i (wh_addr),
    .clear_i   (clear),
    .rd_req_i  (rd_req),
    .rd_data_o (rd_data),
    .rd_vld_o  (rd_vld)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic drive_idle();
    stage         = '0;
    feat_wr       = '0;
    wh_addr       = '0;
    clear         = 1'b0;
    rd_req.strobe = 1'b0;
    rd_req.addr   = REG_SIGNATURE;
  endtask

  task automatic check_word(input dbg_word_t got, input dbg_word_t exp, input string what);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("MISMATCH at %0d ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apply_event(input test_rec_t rec);
    for (int i = 0; i < `SPPE_LANES; i++) begin
      rng_state = xorshift32(rng_state);
      sppe[i]   = rng_state[`SPPE_W-1:0];           // noise on the other lanes.
    end
    sppe[`CAPTURE_LANE] = rec.value[`SPPE_W-1:0];
    stage        = rec.stage;
    feat_wr.ena  = rec.feat_ena;
    feat_wr.addr = rec.feat_addr;
    feat_wr.data = rng_state;
    wh_addr      = rec.wh_addr;
    @(negedge clk);
    drive_idle();
  endtask

  task automatic apply_clear(input test_rec_t rec);
    stage = rec.stage;                              // strobes racing the clear.
    clear = 1'b1;
    @(negedge clk);
    drive_idle();
  endtask

  task automatic read_register(input test_rec_t rec);
    int waited;
    rd_req.strobe = 1'b1;
    rd_req.addr   = rec.rd_addr;
    @(negedge clk);
    rd_req.strobe = 1'b0;
    waited = 0;
    while (!rd_vld && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (rd_vld) begin
      check_word(rd_data, rec.value, rec.rd_addr.name());
    end else begin
      $display("read response missing for %s at %0d ns", rec.rd_addr.name(), $time);
      errors++;
      test_errors++;
    end
  endtask

  task automatic close_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
    tests_run++;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic load_tests();
    int          fd;
    int          n;
    int          v0;
    int          v1;
    int          v2;
    int          v3;
    int          v4;
    bit          ok;
    string       line;
    string       name;
    test_rec_t   rec;
    dbg_status_u status;
    fd = $fopen("verification/debug_monitor_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open verification/debug_monitor_tests.txt, no tests were run");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        while (line.len() > 0 && line[line.len()-1] inside {8'h0a, 8'h0d}) begin
          line = line.substr(0, line.len() - 2);
        end
        if (n > 0 && line.len() > 0 && line[0] != "#") begin
          rec      = '0;
          name     = "";
          rec.kind = line[0];
          case (line[0])
            "E": begin
              ok            = ($sscanf(line, "E %h %d %d %d %h", v0, v1, v2, v3, v4) == 5);
              rec.stage     = v0[7:0];
              rec.feat_ena  = v1[0];
              rec.feat_addr = v2[`FEAT_ADDR_W-1:0];
              rec.wh_addr   = v3[`WH_ADDR_W-1:0];
              rec.value     = v4;
            end
            "C": begin
              ok        = ($sscanf(line, "C %h", v0) == 1);
              rec.stage = v0[7:0];
            end
            "R": begin
              ok          = ($sscanf(line, "R %d %h", v0, v1) == 2);
              rec.rd_addr = dbg_reg_e'(v0[`DBG_ADDR_W-1:0]);
              rec.value   = v1;
            end
            "S": begin
              // status read, expected word built from its flags.
              ok                          = ($sscanf(line, "S %d %d %h", v0, v1, v2) == 3);
              status.raw                  = '0;
              status.fields.feat_ovf_seen = v0[0];
              status.fields.feat_ena_seen = v1[0];
              status.fields.stage         = v2[7:0];
              rec.kind                    = "R";
              rec.rd_addr                 = REG_STATUS;
              rec.value                   = status.raw;
            end
            "T": begin
              ok   = (line.len() > 2);
              name = line.substr(2, line.len() - 1);
            end
            default: begin
              ok = 1'b0;
            end
          endcase
          if (ok) begin
            recs.push_back(rec);
            names.push_back(name);
          end else begin
            $display("unreadable line in test file: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    sppe  = '0;
    drive_idle();
    load_tests();
    loaded = 1'b1;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < recs.size(); i++) begin
      if (recs[i].kind != "T") begin
        rng_state = xorshift32(rng_state);
        repeat (rng_state[1:0]) @(negedge clk);     // 0 to 3 idle cycles.
      end
      case (recs[i].kind)
        "E": apply_event(recs[i]);
        "C": apply_clear(recs[i]);
        "R": read_register(recs[i]);
        default: close_test(names[i]);
      endcase
    end
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // run length bound from the record count.
  initial begin
    wait (loaded);
    repeat (recs.size() * 8 + 50) @(posedge clk);
    $display("watchdog expired after %0d cycles, the test run did not complete",
             recs.size() * 8 + 50);
    $display("Errors found");
    $finish;
  end

endmodule
